//--- Bender.yml
package:
  name: cpu_core

sources:
  - design/cpu_pkg.sv
  - design/reg_file.sv
  - design/instr_decode.sv
  - design/alu.sv
  - design/cond_eval.sv
  - design/stage_sequencer.sv
  - design/cpu_core.sv
  - target: simulation
    files:
      - bench/mem_model.sv
      - bench/tb_cpu_core.sv

//--- bench/mem_model.sv
/*
 * Word-addressed memory for the testbench. Each one-cycle request is
 * answered with 1 to 4 busy cycles. The testbench loads and reads the array.
 */
`timescale 1ns/100ps

module mem_model import cpu_pkg::*; #(
  parameter int ADDR_W = 10
) (
  input  logic     clk,
  input  logic     reset,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp
);

  word_t             mem [0:2**ADDR_W-1];   // Program and data
  integer            seed;
  int                busy_left;             // Busy cycles still to go
  logic [ADDR_W-1:0] addr_q;
  logic              read_q;

  initial begin
    seed      = 32'hf39d_1e0f;
    mem_rsp   = '0;
    busy_left = 0;
    read_q    = 1'b0;
    addr_q    = '0;
  end

  always @(posedge clk) begin
    if (reset) begin
      mem_rsp.busy <= 1'b0;
      busy_left    <= 0;
      read_q       <= 1'b0;
    end else if (mem_req.read || mem_req.write) begin
      if (mem_req.write) begin
        mem[mem_req.addr[ADDR_W-1:0]] <= mem_req.wdata;
      end
      addr_q       <= mem_req.addr[ADDR_W-1:0];
      read_q       <= mem_req.read;
      mem_rsp.busy <= 1'b1;
      busy_left    <= 1 + int'($unsigned($random(seed)) % 4);
    end else if (busy_left > 1) begin
      busy_left <= busy_left - 1;
    end else if (busy_left == 1) begin
      busy_left    <= 0;
      mem_rsp.busy <= 1'b0;   // Access completes in this cycle
      if (read_q) begin
        mem_rsp.rdata <= mem[addr_q];
      end
    end
  end

endmodule

//--- bench/tb_cpu_core.sv
/*
 * Directed testbench for the multi-cycle core. Each test loads a small
 * program into the memory model, runs it up to a marker store and then
 * checks the words the program left in memory.
 */
`timescale 1ns/100ps

module tb_cpu_core import cpu_pkg::*; ();

  localparam int ADDR_W          = 10;
  localparam int PC_W            = ADDR_W - 1;
  localparam int N_TESTS         = 6;
  localparam int WATCHDOG_CYCLES = N_TESTS * 200 * 4;   // Worst-case busy of 4
  localparam logic [15:0] MARK_ADDR = 16'h03f0;

  logic            clk;
  logic            reset;
  mem_req_t        mem_req;
  mem_rsp_t        mem_rsp;
  logic [PC_W-1:0] pc;
  instr_u          ir;

  word_t prog [$];          // Program under construction
  int    exp_addrs [$];
  word_t exp_words [$];
  int    error_count;
  int    tests_run;
  int    tests_bad;

  cpu_core #(.ADDR_W(ADDR_W)) UUT (
    .clk, .reset, .mem_req, .mem_rsp, .pc, .ir
  );

  mem_model #(.ADDR_W(ADDR_W)) u_mem (
    .clk, .reset, .mem_req, .mem_rsp
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //----------------------------------------
  // Instruction encoding
  //----------------------------------------
  task automatic alu_instr(input cond_t cond, input logic set, input reg_addr_t rd,
                           input reg_addr_t ra, input reg_addr_t rb, input alu_op_t op);
    instr_u w;
    w = '0;
    w.rtype.opcode = OP_ALU;
    w.rtype.cond   = cond;
    w.rtype.set    = set;
    w.rtype.ra     = ra;
    w.rtype.rb     = rb;
    w.rtype.rd     = rd;
    w.rtype.alu_op = op;
    prog.push_back(word_t'(w));
  endtask

  task automatic imm_instr(input opcode_t op, input reg_addr_t rt, input reg_addr_t rs,
                           input logic [15:0] imm);
    instr_u w;
    w = '0;
    w.itype.opcode = op;
    w.itype.rs     = rs;
    w.itype.rt     = rt;
    w.itype.imm    = imm;
    prog.push_back(word_t'(w));
  endtask

  task automatic store_instr(input reg_addr_t rt, input reg_addr_t rs, input logic [15:0] imm);
    imm_instr(OP_STW, rt, rs, imm);
  endtask

  task automatic load_instr(input reg_addr_t rt, input reg_addr_t rs, input logic [15:0] imm);
    imm_instr(OP_LDW, rt, rs, imm);
  endtask

  // Condition sits in the rs bits of the immediate layout
  task automatic branch_instr(input cond_t cond, input logic [15:0] offset);
    imm_instr(OP_B, '0, reg_addr_t'(cond), offset);
  endtask

  task automatic const_to_reg(input reg_addr_t rd, input word_t value);
    imm_instr(OP_ADDIH, rd, '0, value[31:16]);
    imm_instr(OP_ORIL, rd, rd, value[15:0]);
  endtask

  task automatic marker_store();
    store_instr('0, '0, MARK_ADDR);
  endtask

  //----------------------------------------
  // Reference model
  //----------------------------------------
  function automatic word_t sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic flags_t expected_flags(input logic is_sub, input word_t a, input word_t b);
    flags_t f;
    word_t  r;
    longint exact;
    if (is_sub) begin
      r     = a - b;
      exact = longint'($signed(a)) - longint'($signed(b));
      f.c   = (a >= b);   // No borrow
    end else begin
      r     = a + b;
      exact = longint'($signed(a)) + longint'($signed(b));
      f.c   = (64'(a) + 64'(b)) > 64'hffff_ffff;
    end
    f.n = r[31];
    f.z = (r == '0);
    f.v = (exact != longint'($signed(r)));
    return f;
  endfunction

  function automatic logic cond_holds(input cond_t c, input flags_t f);
    case (c)
      COND_EQ: return f.z;
      COND_NE: return !f.z;
      COND_HS: return f.c;
      COND_LO: return !f.c;
      COND_MI: return f.n;
      COND_PL: return !f.n;
      COND_VS: return f.v;
      COND_VC: return !f.v;
      COND_HI: return f.c && !f.z;
      COND_LS: return !f.c || f.z;
      COND_GE: return !(f.n ^ f.v);
      COND_LT: return f.n ^ f.v;
      COND_GT: return !f.z && !(f.n ^ f.v);
      COND_LE: return f.z || (f.n ^ f.v);
      COND_AL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // NOOP opcode with the address in the low half
  function automatic word_t fill_word(input int addr);
    return {6'b00_0000, 10'h2b5, 16'(addr)};
  endfunction

  //----------------------------------------
  // Checks and run control
  //----------------------------------------
  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t, %s, expected %h, got %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_addr(input string name, input logic [PC_W-1:0] expected,
                            input logic [PC_W-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t, %s, expected %h, got %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("At %0t: %s", $time, what);
    error_count++;
  endtask

  task automatic expect_word(input int addr, input word_t value);
    exp_addrs.push_back(addr);
    exp_words.push_back(value);
  endtask

  task automatic check_stored();
    foreach (exp_addrs[i]) begin
      check_word($sformatf("mem[%h]", exp_addrs[i]), exp_words[i], u_mem.mem[exp_addrs[i]]);
    end
    exp_addrs.delete();
    exp_words.delete();
  endtask

  task automatic write_program();
    for (int a = 0; a < 2**ADDR_W; a++) begin
      u_mem.mem[a] = fill_word(a);
    end
    foreach (prog[i]) begin
      u_mem.mem[i] = prog[i];
    end
  endtask

  // Five reset cycles with the memory loaded during reset
  task automatic start_program();
    @(posedge clk);
    reset <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    write_program();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic wait_marker();
    logic hit;
    hit = 1'b0;
    while (!hit) begin
      @(negedge clk);
      hit = mem_req.write && (mem_req.addr == ADDR_W_MAX'(MARK_ADDR));
    end
    @(posedge clk);   // Marker lands in memory
    @(negedge clk);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d mismatches", name, error_count - errs_before);
    end
  endtask

  //----------------------------------------
  // Directed tests
  //----------------------------------------
  task automatic test_immediates();
    int    errs;
    word_t r3;
    errs = error_count;
    prog.delete();
    imm_instr(OP_ADDIL, 1, 0, 16'h8123);
    imm_instr(OP_ADDIH, 2, 0, 16'h1234);
    imm_instr(OP_ORIL, 3, 2, 16'habcd);
    imm_instr(OP_ORIH, 4, 3, 16'h4001);
    imm_instr(OP_ANDIL, 5, 3, 16'h00f0);
    imm_instr(OP_ANDIH, 6, 3, 16'hf0f0);
    for (int i = 1; i <= 6; i++) begin
      store_instr(reg_addr_t'(i), 0, 16'h0200 + 16'(i - 1));
    end
    marker_store();
    r3 = {16'h1234, 16'h0000} | {16'h0000, 16'habcd};
    expect_word(32'h200, sext16(16'h8123));
    expect_word(32'h201, {16'h1234, 16'h0000});
    expect_word(32'h202, r3);
    expect_word(32'h203, r3 | {16'h4001, 16'h0000});
    expect_word(32'h204, r3 & {16'hffff, 16'h00f0});   // Ones above
    expect_word(32'h205, r3 & {16'hf0f0, 16'hffff});   // Ones below
    start_program();
    wait_marker();
    check_stored();
    end_test("immediates", errs);
  endtask

  task automatic test_alu_ops();
    int    errs;
    word_t a;
    word_t b;
    errs = error_count;
    a = 32'h89ab_cdef;
    b = 32'h1357_9bdf;
    prog.delete();
    const_to_reg(1, a);
    const_to_reg(2, b);
    alu_instr(COND_AL, 1'b0, 3, 1, 2, ALU_ADD);
    alu_instr(COND_AL, 1'b0, 4, 1, 2, ALU_SUB);
    alu_instr(COND_AL, 1'b0, 5, 1, 2, ALU_AND);
    alu_instr(COND_AL, 1'b0, 6, 1, 2, ALU_OR);
    alu_instr(COND_AL, 1'b0, 7, 1, 2, ALU_XOR);
    imm_instr(OP_ADDIL, 8, 0, 16'h0005);
    alu_instr(COND_AL, 1'b0, 0, 1, 2, ALU_ADD);   // Lost write to r0
    alu_instr(COND_AL, 1'b0, 8, 0, 0, ALU_ADD);
    for (int i = 3; i <= 8; i++) begin
      store_instr(reg_addr_t'(i), 0, 16'h0210 + 16'(i - 3));
    end
    store_instr(0, 0, 16'h0216);
    marker_store();
    expect_word(32'h210, a + b);
    expect_word(32'h211, a - b);
    expect_word(32'h212, a & b);
    expect_word(32'h213, a | b);
    expect_word(32'h214, a ^ b);
    expect_word(32'h215, '0);
    expect_word(32'h216, '0);
    start_program();
    wait_marker();
    check_stored();
    end_test("alu_ops", errs);
  endtask

  // One flag-setting op, then two conditional writes of r10 into r11 and r12
  task automatic flag_case(input int k, input logic is_sub, input word_t a, input word_t b,
                           input cond_t c1, input cond_t c2);
    flags_t f;
    f = expected_flags(is_sub, a, b);
    const_to_reg(1, a);
    const_to_reg(2, b);
    alu_instr(COND_AL, 1'b1, 3, 1, 2, is_sub ? ALU_SUB : ALU_ADD);
    alu_instr(c1, 1'b0, 11, 10, 0, ALU_ADD);
    alu_instr(c2, 1'b0, 12, 10, 0, ALU_ADD);
    store_instr(11, 0, 16'h0220 + 16'(2 * k));
    store_instr(12, 0, 16'h0221 + 16'(2 * k));
    imm_instr(OP_ADDIL, 11, 0, 16'h0000);
    imm_instr(OP_ADDIL, 12, 0, 16'h0000);
    expect_word(32'h220 + 2 * k, cond_holds(c1, f) ? 32'd1 : 32'd0);
    expect_word(32'h221 + 2 * k, cond_holds(c2, f) ? 32'd1 : 32'd0);
  endtask

  task automatic test_flags();
    int errs;
    errs = error_count;
    prog.delete();
    imm_instr(OP_ADDIL, 10, 0, 16'h0001);
    flag_case(0, 1'b1, 32'd5, 32'd5, COND_EQ, COND_NE);
    flag_case(1, 1'b1, 32'd3, 32'd7, COND_HS, COND_LO);          // Borrow
    flag_case(2, 1'b0, 32'h7fff_ffff, 32'd1, COND_VS, COND_VC);
    flag_case(3, 1'b1, 32'hffff_fffe, 32'd3, COND_GE, COND_LT);
    flag_case(4, 1'b1, 32'h8000_0000, 32'd1, COND_GE, COND_LT);  // Overflow
    flag_case(5, 1'b0, 32'hffff_ffff, 32'd1, COND_HS, COND_LO);  // Carry out
    marker_store();
    start_program();
    wait_marker();
    check_stored();
    end_test("flags", errs);
  endtask

  task automatic test_branch();
    int     errs;
    flags_t f;
    logic   taken_eq;
    logic   taken_ne;
    errs = error_count;
    f = expected_flags(1'b1, 32'd1, 32'd1);
    taken_eq = cond_holds(COND_EQ, f);
    taken_ne = cond_holds(COND_NE, f);
    prog.delete();
    imm_instr(OP_ADDIL, 1, 0, 16'h0001);
    imm_instr(OP_ADDIL, 2, 0, 16'h0002);
    alu_instr(COND_AL, 1'b1, 3, 1, 1, ALU_SUB);
    branch_instr(COND_EQ, 16'd3);   // At address 3 and skips two stores
    store_instr(1, 0, 16'h0240);
    store_instr(1, 0, 16'h0241);
    store_instr(2, 0, 16'h0242);
    branch_instr(COND_NE, 16'd2);   // Address 7
    store_instr(2, 0, 16'h0243);
    branch_instr(COND_AL, 16'd2);   // Address 9
    store_instr(1, 0, 16'h0244);
    store_instr(2, 0, 16'h0245);
    marker_store();
    expect_word(32'h240, taken_eq ? fill_word(32'h240) : 32'd1);
    expect_word(32'h241, taken_eq ? fill_word(32'h241) : 32'd1);
    expect_word(32'h242, 32'd2);
    expect_word(32'h243, taken_ne ? fill_word(32'h243) : 32'd2);
    expect_word(32'h244, fill_word(32'h244));
    expect_word(32'h245, 32'd2);
    start_program();
    wait_marker();
    check_stored();
    end_test("branch", errs);
  endtask

  task automatic test_load_store();
    int    errs;
    word_t v;
    errs = error_count;
    prog.delete();
    imm_instr(OP_ADDIL, 1, 0, 16'h0300);   // Base register
    for (int i = 0; i < 4; i++) begin
      v = 32'h9e37_79b9 * (i + 1);
      const_to_reg(2, v);
      store_instr(2, 1, 16'(-(i + 1)));
      load_instr(3, 1, 16'(-(i + 1)));
      store_instr(3, 0, 16'h0310 + 16'(i));
      expect_word(32'h300 - (i + 1), v);
      expect_word(32'h310 + i, v);
    end
    marker_store();
    start_program();
    wait_marker();
    check_stored();
    end_test("load_store", errs);
  endtask

  task automatic test_reset();
    int   errs;
    logic got_req;
    logic seen_busy;
    logic done;
    errs = error_count;
    got_req = 1'b0;
    seen_busy = 1'b0;
    done = 1'b0;
    prog.delete();
    const_to_reg(1, 32'h5555_aaaa);
    store_instr(1, 0, 16'h0280);
    for (int i = 0; i < 10; i++) begin
      alu_instr(COND_AL, 1'b0, 2, 2, 1, ALU_XOR);
    end
    marker_store();
    expect_word(32'h280, 32'h5555_aaaa);
    start_program();
    repeat (40) @(posedge clk);   // Well inside the program
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_addr("pc", '0, pc);
    if (mem_req.read || mem_req.write) begin
      report_failure("memory request active while reset is held");
    end
    u_mem.mem[32'h280] = '0;
    @(posedge clk);
    reset <= 1'b0;
    // First request must be the fetch at 0 with no write before it completes
    while (!done) begin
      @(negedge clk);
      if (mem_req.write) begin
        report_failure("write request before the first fetch completed");
      end
      if (!got_req) begin
        if (mem_req.read) begin
          got_req = 1'b1;
          check_word("mem_req.addr", '0, word_t'(mem_req.addr));
        end
      end else if (mem_rsp.busy) begin
        seen_busy = 1'b1;
      end else if (seen_busy) begin
        done = 1'b1;
      end
    end
    check_addr("pc", '0, pc);
    @(negedge clk);
    check_word("ir", prog[0], word_t'(ir));   // First word of the program
    wait_marker();
    check_stored();
    end_test("reset", errs);
  endtask

  //----------------------------------------
  // Main sequence and watchdog
  //----------------------------------------
  initial begin
    reset = 1'b1;
    error_count = 0;
    tests_run = 0;
    tests_bad = 0;
    test_immediates();
    test_alu_ops();
    test_flags();
    test_branch();
    test_load_store();
    test_reset();
    $display("summary: %0d tests run, %0d with mismatches, %0d errors",
             tests_run, tests_bad, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired, a test did not reach its marker store");
    $display("tests failed");
    $finish;
  end

endmodule

//--- design/alu.sv
/*
 * Combinational ALU with N, Z, C and V generation.
 * Unknown operation codes give a zero result.
 */
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
  input  alu_op_t op,
  input  word_t   in_a,
  input  word_t   in_b,
  output word_t   result,
  output flags_t  flags
);

  logic [32:0] sum;
  logic [32:0] diff;
  logic        carry;
  logic        ovf;

  // 33 bits wide so bit 32 holds the carry or borrow
  assign sum  = {1'b0, in_a} + {1'b0, in_b};
  assign diff = {1'b0, in_a} - {1'b0, in_b};

  always_comb begin
    carry = 1'b0;
    ovf   = 1'b0;
    case (op)
      ALU_ADD: begin
        result = sum[31:0];
        carry  = sum[32];
        ovf    = (in_a[31] == in_b[31]) && (sum[31] != in_a[31]);
      end
      ALU_SUB: begin
        result = diff[31:0];
        carry  = ~diff[32];   // Set when no borrow
        ovf    = (in_a[31] != in_b[31]) && (diff[31] != in_a[31]);
      end
      ALU_AND: result = in_a & in_b;
      ALU_OR:  result = in_a | in_b;
      ALU_XOR: result = in_a ^ in_b;
      default: result = '0;
    endcase
  end

  //----------------------------------------
  // Flag outputs
  //----------------------------------------
  assign flags = '{n: result[31], z: (result == '0), c: carry, v: ovf};

endmodule

//--- design/cond_eval.sv
/*
 * Persistent flag register and branch/execute condition check.
 * The flags load one edge after flags_we; cond_pass reads the stored copy.
 */
`timescale 1ns/100ps

module cond_eval import cpu_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  flags_t flags_in,
  input  logic   flags_we,
  input  cond_t  cond,
  output logic   cond_pass
);

  flags_t fl;

  always_ff @(posedge clk) begin
    if (reset) begin
      fl <= '0;
    end else if (flags_we) begin
      fl <= flags_in;
    end
  end

  always_comb begin
    cond_pass = 1'b0;   // NV never passes
    case (cond)
      COND_EQ: cond_pass = fl.z;
      COND_NE: cond_pass = ~fl.z;
      COND_HS: cond_pass = fl.c;
      COND_LO: cond_pass = ~fl.c;
      COND_MI: cond_pass = fl.n;
      COND_PL: cond_pass = ~fl.n;
      COND_VS: cond_pass = fl.v;
      COND_VC: cond_pass = ~fl.v;
      COND_HI: cond_pass = fl.c & ~fl.z;
      COND_LS: cond_pass = ~fl.c | fl.z;
      COND_GE: cond_pass = (fl.n == fl.v);
      COND_LT: cond_pass = (fl.n != fl.v);
      COND_GT: cond_pass = ~fl.z & (fl.n == fl.v);
      COND_LE: cond_pass = fl.z | (fl.n != fl.v);
      COND_AL: cond_pass = 1'b1;
      default: ;
    endcase
  end

endmodule

//--- design/cpu_core.sv
/*
 * Top level of the core. Ties the sequencer, decoder, register file,
 * ALU and condition block together and exposes the memory port.
 */
`timescale 1ns/100ps

module cpu_core import cpu_pkg::*; #(
  parameter int ADDR_W = 26            // Memory word-address width
) (
  input  logic              clk,
  input  logic              reset,
  output mem_req_t          mem_req,
  input  mem_rsp_t          mem_rsp,
  output logic [ADDR_W-2:0] pc,
  output instr_u            ir
);

  // Decode fields
  reg_addr_t    src_a;
  reg_addr_t    src_b;
  reg_addr_t    dest;
  word_t        imm;
  alu_op_t      alu_op;
  instr_class_t instr_class;
  logic         set_flags;
  cond_t        cond;

  // Datapath
  word_t     rf_rd_a;
  word_t     rf_rd_b;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_result;
  flags_t    alu_flags;
  logic      flags_we;
  logic      cond_pass;
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  stage_sequencer #(.ADDR_W(ADDR_W)) u_seq (
    .clk, .reset,
    .mem_req, .mem_rsp,
    .pc, .ir,
    .dest, .imm, .instr_class, .set_flags,
    .rf_rd_a, .rf_rd_b,
    .alu_a, .alu_b, .alu_result,
    .flags_we, .cond_pass,
    .rf_we, .rf_waddr, .rf_wdata
  );

  instr_decode u_dec (
    .instr(ir),
    .src_a, .src_b, .dest, .imm, .alu_op, .instr_class, .set_flags, .cond
  );

  reg_file u_rf (
    .clk, .reset,
    .rd_addr_a(src_a), .rd_addr_b(src_b),
    .rd_data_a(rf_rd_a), .rd_data_b(rf_rd_b),
    .wr_en(rf_we), .wr_addr(rf_waddr), .wr_data(rf_wdata)
  );

  alu u_alu (
    .op(alu_op), .in_a(alu_a), .in_b(alu_b),
    .result(alu_result), .flags(alu_flags)
  );

  cond_eval u_cond (
    .clk, .reset,
    .flags_in(alu_flags), .flags_we, .cond, .cond_pass
  );

endmodule

//--- design/cpu_pkg.sv
/*
 * Shared types for the multi-cycle core: widths, opcodes, ALU codes,
 * branch conditions, the instruction word layouts and the memory port.
 * Modules pull these in with a wildcard import in their headers.
 */
package cpu_pkg;

  localparam int ADDR_W_MAX = 26;   // Widest word address on the memory port

  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_addr_t;  // 0 is the zero register

  typedef enum logic [5:0] {
    OP_NOOP  = 6'b00_0000,
    OP_B     = 6'b00_0001,
    OP_LDW   = 6'b00_0010,
    OP_ALU   = 6'b00_0011,
    OP_STW   = 6'b00_0110,
    OP_ADDIL = 6'b00_1010,
    OP_ADDIH = 6'b00_1110,
    OP_ORIL  = 6'b01_0010,
    OP_ORIH  = 6'b01_0110,
    OP_ANDIL = 6'b01_1010,
    OP_ANDIH = 6'b01_1110
  } opcode_t;

  typedef enum logic [4:0] {
    ALU_SUB = 5'b00000,
    ALU_ADD = 5'b00010,
    ALU_XOR = 5'b00100,
    ALU_OR  = 5'b00101,
    ALU_AND = 5'b00110
  } alu_op_t;

  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_HS, COND_LO, COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL, COND_NV
  } cond_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  // Register-register layout
  typedef struct packed {
    opcode_t    opcode;
    cond_t      cond;
    logic       set;
    reg_addr_t  ra;
    reg_addr_t  rb;
    reg_addr_t  rd;
    alu_op_t    alu_op;
    logic [3:0] spare;
  } rtype_t;

  // Immediate, load/store and branch layout
  typedef struct packed {
    opcode_t     opcode;
    reg_addr_t   rs;     // Shares bits with rtype cond
    logic        set;
    reg_addr_t   rt;
    logic        spare;
    logic [15:0] imm;
  } itype_t;

  typedef union packed {
    rtype_t rtype;
    itype_t itype;
  } instr_u;

  typedef struct packed {
    logic                  read;
    logic                  write;
    logic [ADDR_W_MAX-1:0] addr;
    word_t                 wdata;
  } mem_req_t;

  typedef struct packed {
    word_t rdata;
    logic  busy;
  } mem_rsp_t;

  typedef enum logic [1:0] {CLS_NONE, CLS_ALU, CLS_MEM, CLS_BRANCH} instr_class_t;

endpackage

//--- design/instr_decode.sv
/*
 * Combinational decoder. Splits the instruction register into register
 * numbers, the extended immediate, the ALU operation and the class.
 */
`timescale 1ns/100ps

module instr_decode import cpu_pkg::*; (
  input  instr_u       instr,
  output reg_addr_t    src_a,
  output reg_addr_t    src_b,
  output reg_addr_t    dest,
  output word_t        imm,
  output alu_op_t      alu_op,
  output instr_class_t instr_class,
  output logic         set_flags,
  output cond_t        cond
);

  logic [15:0] imm16;
  word_t       imm_sext;

  assign imm16    = instr.itype.imm;
  assign imm_sext = {{16{imm16[15]}}, imm16};

  always_comb begin
    // Immediate-form defaults
    src_a       = instr.itype.rs;
    src_b       = '0;
    dest        = instr.itype.rt;
    imm         = imm_sext;
    alu_op      = ALU_ADD;
    instr_class = CLS_ALU;
    set_flags   = instr.itype.set;
    cond        = COND_AL;    // Only ALU and B carry a condition
    case (instr.rtype.opcode)
      OP_ALU: begin
        src_a  = instr.rtype.ra;
        src_b  = instr.rtype.rb;
        dest   = instr.rtype.rd;
        alu_op = instr.rtype.alu_op;
        cond   = instr.rtype.cond;
      end
      OP_B: begin
        src_a       = '0;
        dest        = '0;
        instr_class = CLS_BRANCH;
        set_flags   = 1'b0;
        cond        = instr.rtype.cond;
      end
      OP_LDW: begin
        instr_class = CLS_MEM;
        set_flags   = 1'b0;
      end
      OP_STW: begin
        src_b       = instr.itype.rt;   // Store data
        dest        = '0;
        instr_class = CLS_MEM;
        set_flags   = 1'b0;
      end
      OP_ADDIL: ;
      OP_ADDIH: imm = {imm16, 16'h0000};
      OP_ORIL: begin
        alu_op = ALU_OR;
        imm    = {16'h0000, imm16};
      end
      OP_ORIH: begin
        alu_op = ALU_OR;
        imm    = {imm16, 16'h0000};
      end
      OP_ANDIL: begin
        alu_op = ALU_AND;
        imm    = {16'hffff, imm16};   // Keeps the high half
      end
      OP_ANDIH: begin
        alu_op = ALU_AND;
        imm    = {imm16, 16'hffff};   // Keeps the low half
      end
      default: begin
        src_a       = '0;
        dest        = '0;
        instr_class = CLS_NONE;
        set_flags   = 1'b0;
      end
    endcase
  end

endmodule

//--- design/reg_file.sv
/*
 * General register file, two combinational read ports and one write port.
 * Register 0 is hard zero; registers 1 to 15 are storage.
 */
`timescale 1ns/100ps

module reg_file import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t rd_addr_a,
  input  reg_addr_t rd_addr_b,
  output word_t     rd_data_a,
  output word_t     rd_data_b,
  input  logic      wr_en,
  input  reg_addr_t wr_addr,
  input  word_t     wr_data
);

  word_t regs [1:15];   // No storage behind address 0

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

//--- design/stage_sequencer.sv
/*
 * Stage FSM of the core: fetch wait, decode, execute, memory issue,
 * memory wait and write-back. Owns PC, IR, operand and result registers
 * and drives the one-cycle read/write requests on the memory port.
 */
`timescale 1ns/100ps

module stage_sequencer import cpu_pkg::*; #(
  parameter int ADDR_W = 26
) (
  input  logic              clk,
  input  logic              reset,
  output mem_req_t          mem_req,
  input  mem_rsp_t          mem_rsp,
  output logic [ADDR_W-2:0] pc,
  output instr_u            ir,
  input  reg_addr_t         dest,
  input  word_t             imm,
  input  instr_class_t      instr_class,
  input  logic              set_flags,
  input  word_t             rf_rd_a,
  input  word_t             rf_rd_b,
  output word_t             alu_a,
  output word_t             alu_b,
  input  word_t             alu_result,
  output logic              flags_we,
  input  logic              cond_pass,
  output logic              rf_we,
  output reg_addr_t         rf_waddr,
  output word_t             rf_wdata
);

  localparam int PC_W = ADDR_W - 1;

  typedef enum logic [2:0] {
    S_IDLE, S_FETCH_WAIT, S_DECODE, S_EXECUTE, S_MEM_ISSUE, S_MEM_WAIT, S_WRITEBACK
  } state_t;

  state_t                state;
  logic                  cond_ok;    // Condition latched in decode
  logic                  req_rd;
  logic                  req_wr;
  logic [ADDR_W_MAX-1:0] req_addr;
  word_t                 req_wdata;  // Store data
  word_t                 opnd_a;
  word_t                 opnd_b;
  word_t                 imm_q;
  word_t                 result;
  logic                  is_load;
  logic                  is_mem;
  logic                  fetch_issue;
  logic                  mem_issue;
  logic [PC_W-1:0]       pc_step;

  //----------------------------------------
  // Decisions
  //----------------------------------------
  assign is_load = (ir.rtype.opcode == OP_LDW);
  assign is_mem  = (instr_class == CLS_MEM);
  assign mem_issue = (state == S_EXECUTE) && is_mem;
  assign fetch_issue = (state == S_IDLE) || ((state == S_MEM_ISSUE) && !is_mem) ||
                       ((state == S_MEM_WAIT) && !mem_rsp.busy);
  assign pc_step = (cond_ok && instr_class == CLS_BRANCH) ? imm_q[PC_W-1:0] : PC_W'(1);

  assign alu_a = opnd_a;
  assign alu_b = (ir.rtype.opcode == OP_ALU) ? opnd_b : imm_q;   // Register or immediate
  assign flags_we = (state == S_EXECUTE) && set_flags;

  // Immediates and LDW decode with cond AL, so cond_ok gates every write
  assign rf_we    = (state == S_WRITEBACK) && cond_ok && (instr_class == CLS_ALU || is_load);
  assign rf_waddr = dest;
  assign rf_wdata = result;

  assign mem_req = '{read: req_rd, write: req_wr, addr: req_addr, wdata: req_wdata};

  //----------------------------------------
  // State and control
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= S_IDLE;
      pc      <= '0;
      ir      <= '0;
      cond_ok <= 1'b0;
      req_rd  <= 1'b0;
      req_wr  <= 1'b0;
    end else begin
      req_rd <= fetch_issue || (mem_issue && is_load);   // High for one cycle only
      req_wr <= mem_issue && !is_load;
      case (state)
        S_IDLE:       state <= S_WRITEBACK;   // First fetch goes out, IR still NOOP
        S_FETCH_WAIT: begin
          if (!mem_rsp.busy) begin
            ir    <= instr_u'(mem_rsp.rdata);
            state <= S_DECODE;
          end
        end
        S_DECODE: begin
          cond_ok <= cond_pass;
          state   <= S_EXECUTE;
        end
        S_EXECUTE: begin
          pc    <= pc + pc_step;
          state <= S_MEM_ISSUE;
        end
        S_MEM_ISSUE:  state <= is_mem ? S_MEM_WAIT : S_WRITEBACK;
        S_MEM_WAIT:   if (!mem_rsp.busy) state <= S_WRITEBACK;
        S_WRITEBACK:  state <= S_FETCH_WAIT;
        default:      state <= S_IDLE;
      endcase
    end
  end

  //----------------------------------------
  // Datapath registers
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (state == S_DECODE) begin
      opnd_a <= rf_rd_a;
      opnd_b <= rf_rd_b;
      imm_q  <= imm;
    end
    if (state == S_EXECUTE) begin
      result    <= alu_result;
      req_wdata <= opnd_b;
    end
    if (state == S_MEM_WAIT && !mem_rsp.busy && is_load) begin
      result <= mem_rsp.rdata;   // Load data for write-back
    end
    if (fetch_issue) begin
      req_addr <= ADDR_W_MAX'({1'b0, pc});
    end else if (mem_issue) begin
      req_addr <= ADDR_W_MAX'(alu_result[ADDR_W-1:0]);   // Base plus offset
    end
  end

endmodule

//--- sim.f
design/cpu_pkg.sv
design/reg_file.sv
design/instr_decode.sv
design/alu.sv
design/cond_eval.sv
design/stage_sequencer.sv
design/cpu_core.sv
bench/mem_model.sv
bench/tb_cpu_core.sv
